// File: vlog.f
hw/icache_pkg.sv
hw/tdp_ram.sv
hw/icache_meta.sv
hw/icache_plru.sv
hw/icache.sv
hw/inst_rom.sv
hw/icache_top.sv
tests/icache_tb.sv

// File: Bender.yml
package:
  name: icache

sources:
  - files:
      - hw/icache_pkg.sv
      - hw/tdp_ram.sv
      - hw/icache_meta.sv
      - hw/icache_plru.sv
      - hw/icache.sv
      - hw/inst_rom.sv
      - hw/icache_top.sv
  - target: test
    files:
      - tests/icache_tb.sv

// File: tests/icache_stimulus.txt
// columns: op sel addr_1 addr_2, all hex
// op 1 request, 2 request that must hit, 3 random pairs (count in addr_1), 0 end
// sel 1 word 1 only, 3 both words
1 1 00000040 00000000
1 1 000004a0 00000000
2 1 00000044 00000000
2 3 00000048 0000007c
2 3 000004a4 0000004c
1 3 00000804 00000c38
2 3 00000c3c 00000800
1 3 00001010 00001014
1 3 0000153c 00001540
1 3 0000103c 00001040
2 3 00001000 0000157c
2 3 0000107c 00001544
1 3 00000200 00002200
2 3 00000204 00002208
1 1 00000100 00000000
1 1 00002104 00000000
1 1 00004108 00000000
2 1 00002110 00000000
1 1 0000010c 00000000
2 1 00002100 00000000
3 0 00000040 00000000
0 0 00000000 00000000

// File: tests/icache_tb.sv
module icache_tb;

    localparam int stim_depth = 256;
    localparam int wait_limit = 2000;

    logic              clk;
    logic              resetn;
    logic              req_valid_1;
    icache_pkg::addr_t req_addr_1;
    logic              req_valid_2;
    icache_pkg::addr_t req_addr_2;
    logic              addr_ok;
    logic              data_ok;
    logic [63:0]       rdata;

    // four entries per request: op, sel, addr_1, addr_2
    logic [31:0] stim [stim_depth];
    integer      seed;
    int          data_errors;
    int          latency_errors;
    int          handshake_errors;
    int          other_errors;
    logic        aborted;

    icache_top icache_top_i (
        .clk,
        .resetn,
        .req_valid_1,
        .req_addr_1,
        .req_valid_2,
        .req_addr_2,
        .addr_ok,
        .data_ok,
        .rdata
    );

    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

    // rom word: aligned address xor the pattern
    function automatic icache_pkg::word_t rom_word(icache_pkg::addr_t addr);
        return {addr[31:2], 2'b00} ^ icache_pkg::rom_pattern;
    endfunction

    task automatic check_word(input string name, input icache_pkg::word_t got,
                              input icache_pkg::word_t exp);
        assert (got === exp) else begin
            $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
            data_errors++;
        end
    endtask

    task automatic wait_ready();
        int cycles;
        cycles = 0;
        while (!addr_ok && cycles < wait_limit) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (!addr_ok) begin
            $display("addr_ok never came up after reset");
            other_errors++;
            aborted = 1'b1;
        end
    endtask

    task automatic run_request(input icache_pkg::addr_t a1, input logic v2,
                               input icache_pkg::addr_t a2, input logic want_hit);
        int   cycles;
        logic taken;
        logic seen;
        logic addr_ok_after;
        cycles = 0;
        taken = 1'b0;
        seen = 1'b0;
        @(posedge clk);
        #1;
        req_valid_1 = 1'b1;
        req_addr_1 = a1;
        req_valid_2 = v2;
        req_addr_2 = a2;
        // held until an edge with addr_ok high
        while (!taken && cycles < wait_limit) begin
            #1;
            taken = addr_ok;
            @(posedge clk);
            #1;
            cycles++;
        end
        req_valid_1 = 1'b0;
        req_valid_2 = 1'b0;
        if (!taken) begin
            $display("request to %h was never accepted", a1);
            other_errors++;
            aborted = 1'b1;
            return;
        end
        // state of addr_ok just after the acceptance edge
        addr_ok_after = addr_ok;
        cycles = 0;
        while (!seen && cycles < wait_limit) begin
            @(posedge clk);
            #1;
            cycles++;
            seen = data_ok;
        end
        if (!seen) begin
            $display("no response for the request to %h", a1);
            other_errors++;
            aborted = 1'b1;
            return;
        end
        if (want_hit) begin
            assert (cycles == 1) else begin
                $display("CHECK FAILED at %0t: data_ok latency got %0d expected 1",
                         $time, cycles);
                latency_errors++;
            end
            assert (addr_ok_after === 1'b1) else begin
                $display("CHECK FAILED at %0t: addr_ok after a hit got %b expected 1",
                         $time, addr_ok_after);
                handshake_errors++;
            end
        end else if (cycles > 1) begin
            // a slow response comes from a miss, which closes addr_ok
            assert (addr_ok_after === 1'b0) else begin
                $display("CHECK FAILED at %0t: addr_ok after a miss got %b expected 0",
                         $time, addr_ok_after);
                handshake_errors++;
            end
        end
        check_word("rdata[31:0]", rdata[31:0], rom_word(a1));
        if (v2) begin
            check_word("rdata[63:32]", rdata[63:32], rom_word(a2));
        end
    endtask

    task automatic run_random(input int count);
        icache_pkg::addr_t a1;
        icache_pkg::addr_t a2;
        logic [31:0]       r;
        for (int i = 0; i < count && !aborted; i++) begin
            // 32 KB window, twice the cache size
            a1 = $random(seed) & 32'h0000_7ffc;
            a2 = $random(seed) & 32'h0000_7ffc;
            r = $random(seed);
            run_request(a1, r[0], a2, 1'b0);
        end
    endtask

    initial begin
        int          idx;
        logic [31:0] op;
        seed = 97878;
        data_errors = 0;
        latency_errors = 0;
        handshake_errors = 0;
        other_errors = 0;
        aborted = 1'b0;
        resetn = 1'b1;
        req_valid_1 = 1'b0;
        req_addr_1 = '0;
        req_valid_2 = 1'b0;
        req_addr_2 = '0;
        $readmemh("tests/icache_stimulus.txt", stim);
        repeat (3) @(posedge clk);
        #1;
        resetn = 1'b0;
        wait_ready();
        idx = 0;
        op = stim[0];
        while (!aborted && idx + 3 < stim_depth && op !== 32'h0) begin
            case (op)
                32'h1: run_request(stim[idx+2], stim[idx+1][1], stim[idx+3], 1'b0);
                32'h2: run_request(stim[idx+2], stim[idx+1][1], stim[idx+3], 1'b1);
                32'h3: run_random(stim[idx+2]);
                default: begin
                    $display("unknown operation code %h in the stimulus file", op);
                    other_errors++;
                    aborted = 1'b1;
                end
            endcase
            idx += 4;
            op = stim[idx];
        end
        $display("errors: data %0d, latency %0d, handshake %0d, other %0d",
                 data_errors, latency_errors, handshake_errors, other_errors);
        if (data_errors + latency_errors + handshake_errors + other_errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// File: hw/icache_top.sv
module icache_top #(
    parameter int sets = 128,
    parameter int line_words = 16,
    parameter int mem_wait = 3
) (
    input  logic              clk,
    input  logic              resetn,
    input  logic              req_valid_1,
    input  icache_pkg::addr_t req_addr_1,
    input  logic              req_valid_2,
    input  icache_pkg::addr_t req_addr_2,
    output logic              addr_ok,
    output logic              data_ok,
    output logic [63:0]       rdata
);
    // refill bus
    logic              refill_valid;
    icache_pkg::addr_t refill_addr;
    logic              refill_ready;
    icache_pkg::word_t refill_data;
    logic              refill_last;

    icache #(
        .sets(sets),
        .line_words(line_words)
    ) icache_i (
        .clk,
        .resetn,
        .req_valid_1,
        .req_addr_1,
        .req_valid_2,
        .req_addr_2,
        .addr_ok,
        .data_ok,
        .rdata,
        .refill_valid,
        .refill_addr,
        .refill_ready,
        .refill_data,
        .refill_last
    );

    inst_rom #(
        .line_words(line_words),
        .mem_wait(mem_wait)
    ) inst_rom_i (
        .clk,
        .resetn,
        .refill_valid,
        .refill_addr,
        .refill_ready,
        .refill_data,
        .refill_last
    );

endmodule

// File: hw/inst_rom.sv
module inst_rom #(
    parameter int line_words = 16,
    parameter int mem_wait = 3,
    localparam int offset_bits = $clog2(line_words),
    localparam int line_lsb = offset_bits + icache_pkg::word_shift,
    localparam int wait_bits = $clog2(mem_wait + 2)
) (
    input  logic              clk,
    input  logic              resetn,
    input  logic              refill_valid,
    input  icache_pkg::addr_t refill_addr,
    output logic              refill_ready,
    output icache_pkg::word_t refill_data,
    output logic              refill_last
);
    // the cycle refill_valid rises counts as the first wait cycle
    localparam int load_value = (mem_wait > 0) ? mem_wait - 1 : 0;

    logic                   busy;
    logic [wait_bits-1:0]   wait_cnt;
    logic [offset_bits-1:0] beat;
    icache_pkg::addr_t      beat_addr;

    always_ff @(posedge clk) begin
        if (resetn) begin
            busy <= 1'b0;
            wait_cnt <= '0;
            beat <= '0;
        end else if (!busy) begin
            if (refill_valid) begin
                busy <= 1'b1;
                wait_cnt <= wait_bits'(load_value);
                beat <= '0;
            end
        end else if (wait_cnt != '0) begin
            wait_cnt <= wait_cnt - 1'b1;
        end else begin
            beat <= beat + 1'b1;
            if (refill_last) begin
                busy <= 1'b0;
            end
        end
    end

    assign refill_ready = busy && (wait_cnt == '0);
    // line_words is a power of two
    assign refill_last = refill_ready && (&beat);

    assign beat_addr = {refill_addr[31:line_lsb], beat, {icache_pkg::word_shift{1'b0}}};
    assign refill_data = beat_addr ^ icache_pkg::rom_pattern;

endmodule

// File: hw/icache.sv
module icache #(
    parameter int sets = 128,
    parameter int line_words = 16
) (
    input  logic                      clk,
    input  logic                      resetn,

    input  logic                      req_valid_1,
    input  icache_pkg::addr_t         req_addr_1,
    input  logic                      req_valid_2,
    input  icache_pkg::addr_t         req_addr_2,
    output logic                      addr_ok,
    output logic                      data_ok,
    output logic [63:0]               rdata,

    output logic                      refill_valid,
    output icache_pkg::addr_t         refill_addr,
    input  logic                      refill_ready,
    input  icache_pkg::word_t         refill_data,
    input  logic                      refill_last
);
    localparam int index_bits = $clog2(sets);
    localparam int offset_bits = $clog2(line_words);
    localparam int index_lsb = icache_pkg::word_shift + offset_bits;
    localparam int tag_lsb = index_lsb + index_bits;
    localparam int tag_bits = icache_pkg::phys_bits - tag_lsb;
    localparam int ram_addr_bits = 1 + index_bits + offset_bits;

    typedef logic [index_bits-1:0]    index_t;
    typedef logic [offset_bits-1:0]   offset_t;
    typedef logic [tag_bits-1:0]      tag_t;
    typedef logic [ram_addr_bits-1:0] ram_addr_t;

    function automatic index_t index_of(icache_pkg::addr_t addr);
        return addr[tag_lsb-1:index_lsb];
    endfunction

    function automatic offset_t offset_of(icache_pkg::addr_t addr);
        return addr[index_lsb-1:icache_pkg::word_shift];
    endfunction

    function automatic tag_t tag_of(icache_pkg::addr_t addr);
        return addr[icache_pkg::phys_bits-1:tag_lsb];
    endfunction

    icache_pkg::refill_state_t state;

    // lookup
    logic              hit_1;
    logic              hit_2;
    icache_pkg::way_t  hit_way_1;
    icache_pkg::way_t  hit_way_2;
    logic              sweep_done;
    logic              accept;
    logic              req_miss;
    logic              same_line_req;
    logic              miss_busy;

    // process stage
    icache_pkg::addr_t p_addr_1;
    icache_pkg::addr_t p_addr_2;
    logic              p_new;
    logic              p_hit_1;
    logic              p_hit_2;
    logic              p_all_hit;
    logic              p_same_line;
    icache_pkg::way_t  way_1_q;
    icache_pkg::way_t  way_2_q;
    icache_pkg::way_t  victim_1;
    icache_pkg::way_t  victim_2;

    // refill
    logic              need_1;
    logic              need_2;
    logic              start_1;
    logic              start_2;
    logic              fetching;
    logic              last_taken;
    logic              finish;
    logic              finish_q;
    offset_t           fill_offset;
    icache_pkg::addr_t fill_addr;
    icache_pkg::way_t  fill_way;

    // data array
    logic              rd_go;
    logic              write_beat;
    logic              en_2;
    ram_addr_t         ram_addr_1;
    ram_addr_t         ram_addr_2;
    icache_pkg::strobe_t strobe_2;
    icache_pkg::word_t rdata_1;
    icache_pkg::word_t rdata_2;
    logic              data_ok_q;

    icache_meta #(
        .sets(sets),
        .line_words(line_words)
    ) icache_meta_i (
        .clk,
        .resetn,
        .rd_index_1(index_of(req_addr_1)),
        .rd_tag_1(tag_of(req_addr_1)),
        .rd_index_2(index_of(req_addr_2)),
        .rd_tag_2(tag_of(req_addr_2)),
        .hit_1,
        .hit_way_1,
        .hit_2,
        .hit_way_2,
        .wr_en(last_taken),
        .wr_index(index_of(fill_addr)),
        .wr_way(fill_way),
        .wr_tag(tag_of(fill_addr)),
        .sweep_done
    );

    assign addr_ok = sweep_done && !miss_busy;
    assign accept = req_valid_1 && addr_ok;
    assign req_miss = !hit_1 || (req_valid_2 && !hit_2);
    assign same_line_req = (req_addr_1[icache_pkg::phys_bits-1:index_lsb]
                            == req_addr_2[icache_pkg::phys_bits-1:index_lsb]);

    // addr_ok stays low from a missing request until its last refill
    always_ff @(posedge clk) begin
        if (resetn) begin
            miss_busy <= 1'b0;
            p_new <= 1'b0;
        end else begin
            p_new <= accept;
            if (accept && req_miss) begin
                miss_busy <= 1'b1;
            end else if (finish) begin
                miss_busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            p_addr_1 <= req_addr_1;
            p_addr_2 <= req_addr_2;
            p_hit_1 <= hit_1;
            p_hit_2 <= req_valid_2 && hit_2;
            p_all_hit <= !req_miss;
            p_same_line <= same_line_req;
            way_1_q <= hit_way_1;
            way_2_q <= hit_way_2;
        end else if (start_1) begin
            way_1_q <= victim_1;
            // word 2 shares the line, so it lands in the same way
            if (p_same_line) begin
                way_2_q <= victim_1;
            end
        end else if (start_2) begin
            way_2_q <= victim_2;
        end
    end

    icache_plru #(
        .sets(sets)
    ) icache_plru_i (
        .clk,
        .resetn,
        .index_1(index_of(p_addr_1)),
        .index_2(index_of(p_addr_2)),
        .hit_1(p_new && p_hit_1),
        .hit_way_1(way_1_q),
        .hit_2(p_new && p_hit_2),
        .hit_way_2(way_2_q),
        .fill_1(last_taken && state == icache_pkg::fetch_1),
        .fill_way_1(way_1_q),
        .fill_2(last_taken && state == icache_pkg::fetch_2),
        .fill_way_2(way_2_q),
        .victim_1,
        .victim_2
    );

    assign fetching = (state != icache_pkg::idle);
    assign start_1 = (state == icache_pkg::idle) && need_1;
    assign start_2 = (state == icache_pkg::idle) && !need_1 && need_2;
    assign last_taken = fetching && refill_ready && refill_last;
    assign finish = last_taken
                    && (state == icache_pkg::fetch_2 || (state == icache_pkg::fetch_1 && !need_2));
    assign fill_addr = (state == icache_pkg::fetch_2) ? p_addr_2 : p_addr_1;
    assign fill_way = (state == icache_pkg::fetch_2) ? way_2_q : way_1_q;

    // one idle cycle between the two bursts lets the lru bit settle
    always_ff @(posedge clk) begin
        if (resetn) begin
            state <= icache_pkg::idle;
            need_1 <= 1'b0;
            need_2 <= 1'b0;
            fill_offset <= '0;
            finish_q <= 1'b0;
        end else begin
            finish_q <= finish;
            if (accept) begin
                need_1 <= !hit_1;
                need_2 <= req_valid_2 && !hit_2 && !same_line_req;
            end
            unique case (state)
                icache_pkg::idle: begin
                    fill_offset <= '0;
                    if (start_1) begin
                        state <= icache_pkg::fetch_1;
                    end else if (start_2) begin
                        state <= icache_pkg::fetch_2;
                    end
                end
                icache_pkg::fetch_1: begin
                    if (refill_ready) begin
                        fill_offset <= fill_offset + 1'b1;
                    end
                    if (last_taken) begin
                        state <= icache_pkg::idle;
                        need_1 <= 1'b0;
                    end
                end
                icache_pkg::fetch_2: begin
                    if (refill_ready) begin
                        fill_offset <= fill_offset + 1'b1;
                    end
                    if (last_taken) begin
                        state <= icache_pkg::idle;
                        need_2 <= 1'b0;
                    end
                end
                default: begin
                    state <= icache_pkg::idle;
                end
            endcase
        end
    end

    assign refill_valid = fetching;
    assign refill_addr = {fill_addr[31:index_lsb], {index_lsb{1'b0}}};

    // read both words on an all-hit request or right after the last refill
    assign rd_go = (p_new && p_all_hit) || finish_q;
    assign write_beat = fetching && refill_ready;
    assign en_2 = rd_go || write_beat;
    assign strobe_2 = write_beat ? '1 : '0;
    assign ram_addr_1 = {way_1_q, index_of(p_addr_1), offset_of(p_addr_1)};
    assign ram_addr_2 = fetching ? {fill_way, index_of(fill_addr), fill_offset}
                                 : {way_2_q, index_of(p_addr_2), offset_of(p_addr_2)};

    tdp_ram #(
        .addr_width(ram_addr_bits),
        .data_width($bits(icache_pkg::word_t))
    ) tdp_ram_i (
        .clk,
        .en_1(rd_go),
        .addr_1(ram_addr_1),
        .strobe_1('0),
        .wdata_1('0),
        .rdata_1,
        .en_2,
        .addr_2(ram_addr_2),
        .strobe_2,
        .wdata_2(refill_data),
        .rdata_2
    );

    always_ff @(posedge clk) begin
        if (resetn) begin
            data_ok_q <= 1'b0;
        end else begin
            data_ok_q <= rd_go;
        end
    end

    assign data_ok = data_ok_q;
    assign rdata = {rdata_2, rdata_1};

endmodule

// File: hw/icache_plru.sv
module icache_plru #(
    parameter int sets = 128,
    localparam int index_bits = $clog2(sets)
) (
    input  logic                  clk,
    input  logic                  resetn,

    input  logic [index_bits-1:0] index_1,
    input  logic [index_bits-1:0] index_2,
    input  logic                  hit_1,
    input  icache_pkg::way_t      hit_way_1,
    input  logic                  hit_2,
    input  icache_pkg::way_t      hit_way_2,
    input  logic                  fill_1,
    input  icache_pkg::way_t      fill_way_1,
    input  logic                  fill_2,
    input  icache_pkg::way_t      fill_way_2,

    output icache_pkg::way_t      victim_1,
    output icache_pkg::way_t      victim_2
);
    // bit points at the least recently used way
    logic [sets-1:0] lru_q;
    logic            same_set;

    assign same_set = (index_1 == index_2);

    // a partner hit in the same set protects its way
    assign victim_1 = (same_set && hit_2) ? ~hit_way_2 : lru_q[index_1];
    assign victim_2 = (same_set && hit_1) ? ~hit_way_1 : lru_q[index_2];

    always_ff @(posedge clk) begin
        if (resetn) begin
            lru_q <= '0;
        end else begin
            if (hit_1) begin
                lru_q[index_1] <= ~hit_way_1;
            end else if (fill_1) begin
                lru_q[index_1] <= ~fill_way_1;
            end
            // port 2 last, so it wins when both touch one set
            if (hit_2) begin
                lru_q[index_2] <= ~hit_way_2;
            end else if (fill_2) begin
                lru_q[index_2] <= ~fill_way_2;
            end
        end
    end

endmodule

// File: hw/icache_meta.sv
module icache_meta #(
    parameter int sets = 128,
    parameter int line_words = 16,
    localparam int index_bits = $clog2(sets),
    localparam int offset_bits = $clog2(line_words),
    localparam int tag_bits = icache_pkg::phys_bits - index_bits - offset_bits
                              - icache_pkg::word_shift
) (
    input  logic                  clk,
    input  logic                  resetn,

    input  logic [index_bits-1:0] rd_index_1,
    input  logic [tag_bits-1:0]   rd_tag_1,
    input  logic [index_bits-1:0] rd_index_2,
    input  logic [tag_bits-1:0]   rd_tag_2,
    output logic                  hit_1,
    output icache_pkg::way_t      hit_way_1,
    output logic                  hit_2,
    output icache_pkg::way_t      hit_way_2,

    input  logic                  wr_en,
    input  logic [index_bits-1:0] wr_index,
    input  icache_pkg::way_t      wr_way,
    input  logic [tag_bits-1:0]   wr_tag,

    output logic                  sweep_done
);
    logic                  valid_q [2][sets];
    logic [tag_bits-1:0]   tag_q [2][sets];
    logic [index_bits-1:0] sweep_index;
    logic [1:0]            match_1;
    logic [1:0]            match_2;

    // sweep walks every set once, starting from reset
    always_ff @(posedge clk) begin
        if (resetn) begin
            sweep_index <= '0;
            sweep_done <= 1'b0;
        end else if (!sweep_done) begin
            sweep_index <= sweep_index + 1'b1;
            sweep_done <= &sweep_index;
        end
    end

    always_ff @(posedge clk) begin
        if (resetn || !sweep_done) begin
            valid_q[0][sweep_index] <= 1'b0;
            valid_q[1][sweep_index] <= 1'b0;
        end else if (wr_en) begin
            valid_q[wr_way][wr_index] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            tag_q[wr_way][wr_index] <= wr_tag;
        end
    end

    // both lookups against both ways
    for (genvar w = 0; w < 2; w++) begin : g_way
        assign match_1[w] = valid_q[w][rd_index_1] && (tag_q[w][rd_index_1] == rd_tag_1);
        assign match_2[w] = valid_q[w][rd_index_2] && (tag_q[w][rd_index_2] == rd_tag_2);
    end

    assign hit_1 = |match_1;
    assign hit_way_1 = match_1[1];
    assign hit_2 = |match_2;
    assign hit_way_2 = match_2[1];

endmodule

// File: hw/tdp_ram.sv
module tdp_ram #(
    parameter int addr_width = 11,
    parameter int data_width = 32
) (
    input  logic                    clk,

    input  logic                    en_1,
    input  logic [addr_width-1:0]   addr_1,
    input  logic [data_width/8-1:0] strobe_1,
    input  logic [data_width-1:0]   wdata_1,
    output logic [data_width-1:0]   rdata_1,

    input  logic                    en_2,
    input  logic [addr_width-1:0]   addr_2,
    input  logic [data_width/8-1:0] strobe_2,
    input  logic [data_width-1:0]   wdata_2,
    output logic [data_width-1:0]   rdata_2
);
    localparam int depth = 2 ** addr_width;
    localparam int num_bytes = data_width / 8;

    logic [data_width-1:0] mem [depth];

    always_ff @(posedge clk) begin
        if (en_1) begin
            for (int b = 0; b < num_bytes; b++) begin
                if (strobe_1[b]) begin
                    mem[addr_1][b*8 +: 8] <= wdata_1[b*8 +: 8];
                end
            end
            rdata_1 <= mem[addr_1];
        end
        // port 2 comes last and wins a write collision
        if (en_2) begin
            for (int b = 0; b < num_bytes; b++) begin
                if (strobe_2[b]) begin
                    mem[addr_2][b*8 +: 8] <= wdata_2[b*8 +: 8];
                end
            end
            rdata_2 <= mem[addr_2];
        end
    end

endmodule

// File: hw/icache_pkg.sv
package icache_pkg;

    // one instruction word
    typedef logic [31:0] word_t;

    // byte address, only the low phys_bits are decoded
    typedef logic [31:0] addr_t;

    typedef logic [3:0] strobe_t;

    // two ways, so a single select bit
    typedef logic way_t;

    typedef enum logic [1:0] {
        idle,
        fetch_1,
        fetch_2
    } refill_state_t;

    localparam int phys_bits = 28;

    // byte offset inside a word, burst beats step one word at a time
    localparam int word_shift = 2;

    // rom contents: aligned address xor this
    localparam word_t rom_pattern = 32'h3c5a_a5c3;

endpackage
